/* verilog.f */
+incdir+tb
common/t1_pkg.sv
trailing_ones/block_capture.sv
trailing_ones/t1_locator.sv
trailing_ones/sign_walker.sv
trailing_ones/t1_control.sv
source/t1_top.sv
tb/t1_properties.sv
tb/t1_tb.sv

/* tb/t1_cases.svh */
// directed cases, one row each.
// case_coeffs lists the coefficients from position 15 down to position 0.
// case_expected holds count and signs, signs bit 0 is the first unit met.
localparam int NUM_CASES = 7;

string case_name [NUM_CASES] = '{
    "all zero block",
    "large value at top",
    "units with zeros between",
    "five units saturate",
    "cut off at position 10",
    "single unit at position 0",
    "extreme values"
};

int case_coeffs [NUM_CASES][NUM_COEFFS-1:0] = '{
    '{ 0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,      0,  0,     0},
    '{ 7,  1, -1,  0,  1,  0,  0,  0,  0,  0,  0,  0,  0,      0,  0,     1},
    '{-1,  0,  0,  1,  0,  0, -1,  3,  0,  0,  0,  0,  0,      0,  0,     0},
    '{-1, -1,  1, -1, -1,  0,  0,  0,  0,  0,  0,  0,  0,      0,  0,     0},
    '{ 0,  1,  0, -1,  0, -5,  1, -1,  0,  0,  0,  0,  0,      0,  0,     0},
    '{ 0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,      0,  0,    -1},
    '{ 0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  0,  1, -16384, -1, 16383}
};

t1_result_t case_expected [NUM_CASES] = '{
    '{count: 2'd0, signs: 3'b000},
    '{count: 2'd0, signs: 3'b000},
    '{count: 2'd3, signs: 3'b101},
    '{count: 2'd3, signs: 3'b011},
    '{count: 2'd2, signs: 3'b010},
    '{count: 2'd1, signs: 3'b001},
    '{count: 2'd1, signs: 3'b000}
};

/* tb/t1_tb.sv */
`timescale 1ns/1ps

module t1_tb;
    import t1_pkg::*;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int NUM_RANDOM     = 40;

    logic         clk;
    logic         rst;
    logic         req;
    coeff_block_t block;
    logic         ack;
    t1_result_t   result;

    int errors;
    int tests_run;
    int tests_failed;
    bit timed_out;

    `include "t1_cases.svh"

    t1_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .block  (block),
        .ack    (ack),
        .result (result)
    );

    bind t1_control t1_properties i_props (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ack        (ack),
        .capture_en (capture_en),
        .walk_start (walk_start)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_for_ack(input logic level);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            #1;
            n++;
        end
        while (ack !== level && n < TIMEOUT_CYCLES);
        if (ack !== level)
        begin
            $display("timeout: ack did not go to %0d within %0d cycles", level, TIMEOUT_CYCLES);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before)
        begin
            tests_failed++;
            $display("test %0d %s: fail", tests_run, name);
        end
        else
        begin
            $display("test %0d %s: pass", tests_run, name);
        end
    endtask

    // one full four-phase request, req held hold_cycles edges past ack.
    task automatic run_test(input string name, input coeff_block_t blk,
                            input t1_result_t exp, input int hold_cycles);
        t1_result_t got;
        int         errors_before;
        errors_before = errors;
        block = blk;
        req   = 1'b1;
        wait_for_ack(1'b1);
        if (!timed_out)
        begin
            got = result;
            check_value("result.count", got.count, exp.count);
            check_value("result.signs", got.signs, exp.signs);
            block = '0;  // the captured copy carries the rest.
            repeat (hold_cycles)
            begin
                @(posedge clk);
                #1;
                check_value("ack", ack, 1'b1);
                check_value("result", result, exp);
            end
            req = 1'b0;
            wait_for_ack(1'b0);
        end
        report_test(name, errors_before);
    endtask

    function automatic int coeff_value(input coeff_block_t blk, input int p);
        logic [COEFF_W-1:0] bits;
        int                 v;
        bits = blk.coeff[p];
        v    = int'(bits);
        if (bits[COEFF_W-1])
            v = v - (1 << COEFF_W);  // two's complement.
        return v;
    endfunction

    // scan 15 down to 0, zeros skipped, stop at a larger value or a third unit.
    function automatic t1_result_t expected_t1(input coeff_block_t blk);
        t1_result_t res;
        int         p;
        int         v;
        res = '0;
        p   = NUM_COEFFS - 1;
        while (p >= 0 && res.count < MAX_T1)
        begin
            v = coeff_value(blk, p);
            if (v == 1 || v == -1)
            begin
                res.signs[res.count] = (v == -1);
                res.count            = res.count + 1'b1;
            end
            else if (v != 0)
            begin
                break;
            end
            p--;
        end
        return res;
    endfunction

    function automatic coeff_t random_coeff();
        int pick;
        int mag;
        pick = $urandom_range(0, 7);
        mag  = $urandom_range(2, 5);
        case (pick)
            4:       return coeff_t'(1);
            5:       return coeff_t'(-1);
            6:       return ($urandom_range(0, 1) != 0) ? coeff_t'(mag) : coeff_t'(-mag);
            7:       return coeff_t'($urandom);
            default: return '0;  // zeros dominate, like real residuals.
        endcase
    endfunction

    function automatic coeff_block_t case_block(input int i);
        coeff_block_t blk;
        for (int p = 0; p < NUM_COEFFS; p++)
            blk.coeff[p] = coeff_t'(case_coeffs[i][p]);
        return blk;
    endfunction

    initial
    begin
        coeff_block_t blk;
        t1_result_t   exp;
        int           errors_before;
        clk          = 1'b0;
        rst          = 1'b1;
        req          = 1'b0;
        block        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        void'($urandom(79));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        errors_before = errors;
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_value("ack", ack, 1'b0);
            check_value("result", result, '0);
        end
        report_test("reset and idle", errors_before);

        for (int i = 0; i < NUM_CASES && !timed_out; i++)
            run_test(case_name[i], case_block(i), case_expected[i], 0);

        if (!timed_out)
            run_test("held request", case_block(2), case_expected[2], 6);
        if (!timed_out)
            run_test("request after hold", case_block(4), case_expected[4], 0);

        for (int i = 0; i < NUM_RANDOM && !timed_out; i++)
        begin
            for (int p = 0; p < NUM_COEFFS; p++)
                blk.coeff[p] = random_coeff();
            exp = expected_t1(blk);
            run_test($sformatf("random block %0d", i), blk, exp, $urandom_range(0, 2));
        end

        errors = errors + i_dut.i_control.i_props.fail_count;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, i_dut.i_control.i_props.fail_count);
        if (errors == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tb/t1_properties.sv */
`timescale 1ns/1ps

module t1_properties (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic capture_en,
    input logic walk_start
);

    int fail_count = 0;  // assertion failures so far.

    ack_rises_with_req: assert property (
        @(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
    else
    begin
        $error("ack rose while req was low");
        fail_count++;
    end

    ack_falls_after_req: assert property (
        @(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
    else
    begin
        $error("ack fell while req was still high");
        fail_count++;
    end

    // a new block is taken only after ack has been low for a full cycle.
    capture_only_idle: assert property (
        @(posedge clk) disable iff (rst) capture_en |-> !ack && !$past(ack))
    else
    begin
        $error("capture_en high while ack was high");
        fail_count++;
    end

    no_walk_during_ack: assert property (
        @(posedge clk) disable iff (rst) !(walk_start && ack))
    else
    begin
        $error("walk_start high while ack was high");
        fail_count++;
    end

endmodule

/* source/t1_top.sv */
`timescale 1ns/1ps

module t1_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  t1_pkg::coeff_block_t block,
    output logic                 ack,
    output t1_pkg::t1_result_t   result
);
    import t1_pkg::*;

    coeff_block_t            stored;
    logic [NUM_COEFFS-1:0]   zero_flags;
    logic [NUM_COEFFS-1:0]   unit_flags;
    logic [T1_COUNT_W-1:0]   t1_count;
    logic [MAX_T1-1:0]       t1_signs;
    logic                    capture_en;
    logic                    locate_en;
    logic                    walk_start;
    logic                    walk_done;

    block_capture i_capture (
        .clk        (clk),
        .rst        (rst),
        .capture_en (capture_en),
        .block      (block),
        .stored     (stored),
        .zero_flags (zero_flags),
        .unit_flags (unit_flags)
    );

    t1_locator i_locator (
        .clk        (clk),
        .rst        (rst),
        .locate_en  (locate_en),
        .zero_flags (zero_flags),
        .unit_flags (unit_flags),
        .count      (t1_count)
    );

    sign_walker i_walker (
        .clk        (clk),
        .rst        (rst),
        .walk_start (walk_start),
        .count      (t1_count),
        .stored     (stored),
        .unit_flags (unit_flags),
        .signs      (t1_signs),
        .walk_done  (walk_done)
    );

    t1_control i_control (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .walk_done  (walk_done),
        .capture_en (capture_en),
        .locate_en  (locate_en),
        .walk_start (walk_start),
        .ack        (ack)
    );

    assign result = '{count: t1_count, signs: t1_signs};

endmodule

/* trailing_ones/t1_control.sv */
`timescale 1ns/1ps

module t1_control (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic walk_done,
    output logic capture_en,
    output logic locate_en,
    output logic walk_start,
    output logic ack
);

    typedef enum logic [2:0] {
        st_idle,
        st_locate,
        st_walk,
        st_hold,
        st_release
    } state_t;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            st_idle:
            begin
                if (req)
                    next_state = st_locate;
            end
            st_locate:
            begin
                next_state = st_walk;
            end
            st_walk:
            begin
                if (walk_done)
                    next_state = st_hold;
            end
            st_hold:
            begin
                if (!req)
                    next_state = st_release;  // ack drops on this edge.
            end
            default:
            begin
                next_state = st_idle;  // one turnaround cycle with ack low.
            end
        endcase
    end

    // start pulse lands in the first walk cycle, one edge after locate.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            walk_start <= 1'b0;
        end
        else
        begin
            walk_start <= (state == st_locate);
        end
    end

    assign capture_en = (state == st_idle) && req;
    assign locate_en  = (state == st_locate);
    assign ack        = (state == st_hold);  // straight from the state register.

endmodule

/* trailing_ones/sign_walker.sv */
`timescale 1ns/1ps

module sign_walker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          walk_start,
    input  logic [t1_pkg::T1_COUNT_W-1:0] count,
    input  t1_pkg::coeff_block_t          stored,
    input  logic [t1_pkg::NUM_COEFFS-1:0] unit_flags,
    output logic [t1_pkg::MAX_T1-1:0]     signs,
    output logic                          walk_done
);
    import t1_pkg::*;

    pos_t                  pos;
    pos_t                  cur_pos;
    logic [T1_COUNT_W-1:0] tally;
    logic [T1_COUNT_W-1:0] cur_tally;
    logic [T1_COUNT_W-1:0] next_tally;
    logic [MAX_T1-1:0]     cur_signs;
    logic [MAX_T1-1:0]     next_signs;
    logic                  active;
    logic                  hit;

    // walk_start visits position 15 in the same cycle.
    always_comb
    begin
        cur_pos   = walk_start ? pos_t'(NUM_COEFFS - 1) : pos;
        cur_tally = walk_start ? '0 : tally;
        cur_signs = walk_start ? '0 : signs;

        hit        = unit_flags[cur_pos] && (cur_tally != count);
        next_tally = cur_tally + T1_COUNT_W'(hit);
        next_signs = cur_signs;
        if (hit)
        begin
            next_signs[cur_tally] = stored.coeff[cur_pos][COEFF_W-1];  // msb is the sign.
        end
    end

    // the locator count guarantees all units are found above any blocker.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pos       <= '0;
            tally     <= '0;
            signs     <= '0;
            active    <= 1'b0;
            walk_done <= 1'b0;
        end
        else
        begin
            walk_done <= 1'b0;
            if (walk_start || active)
            begin
                pos       <= cur_pos - 1'b1;
                tally     <= next_tally;
                signs     <= next_signs;
                active    <= (next_tally != count);
                walk_done <= (next_tally == count);  // count 0 ends on the first visit.
            end
        end
    end

endmodule

/* trailing_ones/t1_locator.sv */
`timescale 1ns/1ps

module t1_locator (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          locate_en,
    input  logic [t1_pkg::NUM_COEFFS-1:0] zero_flags,
    input  logic [t1_pkg::NUM_COEFFS-1:0] unit_flags,
    output logic [t1_pkg::T1_COUNT_W-1:0] count
);
    import t1_pkg::*;

    logic [T1_COUNT_W-1:0] scan_count;
    logic                  scan_stop;

    // priority scan from the highest position down.
    // zeros are skipped, units add one, anything else ends the run.
    always_comb
    begin
        scan_count = '0;
        scan_stop  = 1'b0;
        for (int p = NUM_COEFFS - 1; p >= 0; p--)
        begin
            if (!scan_stop && !zero_flags[p])
            begin
                if (unit_flags[p] && (scan_count != MAX_T1))
                begin
                    scan_count = scan_count + 1'b1;
                end
                else
                begin
                    scan_stop = 1'b1;  // large value or fourth unit.
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= '0;
        end
        else if (locate_en)
        begin
            count <= scan_count;  // held until the next block.
        end
    end

endmodule

/* trailing_ones/block_capture.sv */
`timescale 1ns/1ps

module block_capture (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          capture_en,
    input  t1_pkg::coeff_block_t          block,
    output t1_pkg::coeff_block_t          stored,
    output logic [t1_pkg::NUM_COEFFS-1:0] zero_flags,
    output logic [t1_pkg::NUM_COEFFS-1:0] unit_flags
);
    import t1_pkg::*;

    localparam coeff_t PLUS_ONE  = COEFF_W'(1);
    localparam coeff_t MINUS_ONE = {COEFF_W{1'b1}};

    // block is taken once per request, requester may change it after ack.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stored <= '0;
        end
        else if (capture_en)
        begin
            stored <= block;
        end
    end

    // per position classification of the held block.
    always_comb
    begin
        for (int p = 0; p < NUM_COEFFS; p++)
        begin
            zero_flags[p] = (stored.coeff[p] == '0);
            unit_flags[p] = (stored.coeff[p] == PLUS_ONE) ||
                            (stored.coeff[p] == MINUS_ONE);  // +1 or -1.
        end
    end

endmodule

/* common/t1_pkg.sv */
package t1_pkg;

    // coefficient block geometry.
    localparam int COEFF_W    = 15;
    localparam int NUM_COEFFS = 16;
    localparam int POS_W      = 4;

    // trailing-ones limits as used by CAVLC.
    localparam int MAX_T1     = 3;
    localparam int T1_COUNT_W = 2;

    // one residual coefficient, two's complement.
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // scan position, row*4 + column.
    typedef logic [POS_W-1:0] pos_t;

    // 4x4 block; coeff[p] holds the coefficient at position p.
    typedef struct packed {
        coeff_t [NUM_COEFFS-1:0] coeff;
    } coeff_block_t;

    // result handed back on ack.
    typedef struct packed {
        logic [T1_COUNT_W-1:0] count;  // 0..3.
        logic [MAX_T1-1:0]     signs;  // bit 0 is the first unit met, 1 means -1.
    } t1_result_t;

endpackage
